// File: sources.f
+incdir+verification
hw/mmu_pkg.sv
hw/mmu_perm_check.sv
hw/mmu_tlb.sv
hw/mmu_walk_ctrl.sv
hw/mmu_top.sv
verification/mmu_tb.sv

// File: Bender.yml
package:
  name: sv32_mmu

sources:
  - files:
      - hw/mmu_pkg.sv
      - hw/mmu_perm_check.sv
      - hw/mmu_tlb.sv
      - hw/mmu_walk_ctrl.sv
      - hw/mmu_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/mmu_tb.sv

// File: verification/mmu_tb_tests.svh
/*
 * MMU test tasks
 *   Request helper with response timeout
 *   Translation and fault expectations
 *   Bare mode, walk, permission, fault, flush and eviction tests
 */
`ifndef MMU_TB_TESTS_SVH
`define MMU_TB_TESTS_SVH

  // One request, held until the response pulse
  task automatic run_access(input string name, input logic [31:0] va, input logic store,
                            input logic fetch, output logic [33:0] pa, output logic fault,
                            output logic [31:0] fva, output int reads, output int cycles);
    int unsigned reads_before;
    reads_before = mem_reads;
    req_vaddr    = va;
    req_is_store = store;
    req_is_fetch = fetch;
    req_valid    = 1'b1;
    cycles       = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run($sformatf("Timeout: %s got no response for address 0x%h", name, va));
      end
    end while (!resp_valid);
    pa    = resp_paddr;       // Fault flag only valid in the pulse
    fault = resp_page_fault;
    fva   = resp_fault_vaddr;
    reads = mem_reads - reads_before;
    req_valid = 1'b0;
    repeat (2) @(negedge clk);  // Controller sees the release
  endtask

  // exp_reads below zero skips the read count
  task automatic expect_xlat(input string name, input logic [31:0] va, input logic store,
                             input logic fetch, input logic [33:0] exp_pa, input int exp_reads);
    logic [33:0] pa;
    logic        fault;
    logic [31:0] fva;
    int          reads;
    int          cycles;
    run_access(name, va, store, fetch, pa, fault, fva, reads, cycles);
    check_value({name, " fault"}, 34'd0, 34'(fault));
    check_value({name, " paddr"}, exp_pa, pa);
    if (exp_reads >= 0) check_value({name, " reads"}, 34'(exp_reads), 34'(reads));
    if (exp_reads == 0) check_value({name, " latency"}, 34'd1, 34'(cycles));  // Bare or hit
  endtask

  task automatic expect_fault(input string name, input logic [31:0] va, input logic store,
                              input logic fetch);
    logic [33:0] pa;
    logic        fault;
    logic [31:0] fva;
    int          reads;
    int          cycles;
    run_access(name, va, store, fetch, pa, fault, fva, reads, cycles);
    check_value({name, " fault"}, 34'd1, 34'(fault));
    check_value({name, " fault_vaddr"}, 34'(va), 34'(fva));
  endtask

  task automatic pulse_flush(input logic all, input logic [31:0] addr);
    flush_all   = all;
    flush_vaddr = !all;
    flush_addr  = addr;
    @(negedge clk);
    flush_all   = 1'b0;
    flush_vaddr = 1'b0;
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  task automatic bare_mode_pass();
    satp = 32'h0;
    expect_xlat("bare satp off", 32'hDEAD_BEEF, 1'b0, 1'b0, 34'h0_DEAD_BEEF, 0);
    satp      = SATP_SV32;
    priv_mode = mmu_pkg::PRIV_M;  // M mode bypasses Sv32
    expect_xlat("bare M mode", 32'h8000_1234, 1'b1, 1'b0, 34'h0_8000_1234, 0);
    priv_mode = mmu_pkg::PRIV_S;
  endtask

  task automatic walk_then_hit();
    expect_xlat("walk first", page_va(0, 12'h5A4), 1'b0, 1'b0, {leaf_ppn(0), 12'h5A4}, 2);
    expect_xlat("hit second", page_va(0, 12'h010), 1'b1, 1'b0, {leaf_ppn(0), 12'h010}, 0);
  endtask

  task automatic permission_rules();
    expect_fault("S to U page", page_va(3, 12'h100), 1'b0, 1'b0);
    sum = 1'b1;
    expect_xlat("S to U page SUM", page_va(3, 12'h100), 1'b0, 1'b0, {leaf_ppn(3), 12'h100}, -1);
    sum = 1'b0;
    expect_fault("store to RO", page_va(2, 12'h008), 1'b1, 1'b0);
    expect_fault("fetch no X", page_va(1, 12'h040), 1'b0, 1'b1);
    priv_mode = mmu_pkg::PRIV_U;
    expect_fault("U to S page", page_va(1, 12'h044), 1'b0, 1'b0);
    priv_mode = mmu_pkg::PRIV_S;
    expect_fault("load X only", page_va(4, 12'h0C0), 1'b0, 1'b0);
    mxr = 1'b1;                   // X pages now readable
    expect_xlat("load X only MXR", page_va(4, 12'h0C0), 1'b0, 1'b0, {leaf_ppn(4), 12'h0C0}, -1);
    mxr = 1'b0;
  endtask

  task automatic walk_faults();
    expect_fault("invalid L0 PTE", page_va(5, 12'h000), 1'b0, 1'b0);
    expect_fault("invalid L1 PTE", 32'h0080_0123, 1'b0, 1'b0);
    expect_fault("pointer at L0", page_va(6, 12'h200), 1'b0, 1'b0);
    expect_fault("leaf at L1", 32'h00C0_0456, 1'b0, 1'b0);  // No superpages
  endtask

  task automatic flush_behavior();
    pulse_flush(1'b1, 32'h0);
    expect_xlat("flush fill 0", page_va(0, 12'h0), 1'b0, 1'b0, {leaf_ppn(0), 12'h0}, 2);
    expect_xlat("flush fill 1", page_va(1, 12'h4), 1'b0, 1'b0, {leaf_ppn(1), 12'h4}, 2);
    pulse_flush(1'b0, page_va(0, 12'hFFF));
    expect_xlat("flush_vaddr walk", page_va(0, 12'h8), 1'b0, 1'b0, {leaf_ppn(0), 12'h8}, 2);
    expect_xlat("flush_vaddr hit", page_va(1, 12'hC), 1'b0, 1'b0, {leaf_ppn(1), 12'hC}, 0);
    pulse_flush(1'b1, 32'h0);
    expect_xlat("flush_all walk 0", page_va(0, 12'h0), 1'b0, 1'b0, {leaf_ppn(0), 12'h0}, 2);
    expect_xlat("flush_all walk 1", page_va(1, 12'h0), 1'b0, 1'b0, {leaf_ppn(1), 12'h0}, 2);
  endtask

  task automatic round_robin_evict();
    pulse_flush(1'b1, 32'h0);
    for (int i = 0; i <= TLB_ENTRIES; i++) begin  // One page more than the TLB holds
      expect_xlat("evict fill", page_va(8 + i, 12'h300), 1'b0, 1'b0,
                  {leaf_ppn(8 + i), 12'h300}, 2);
    end
    expect_xlat("evicted first page", page_va(8, 12'h310), 1'b0, 1'b0,
                {leaf_ppn(8), 12'h310}, 2);
    expect_xlat("newest page hit", page_va(8 + TLB_ENTRIES, 12'h320), 1'b0, 1'b0,
                {leaf_ppn(8 + TLB_ENTRIES), 12'h320}, 0);
  endtask

`endif

// File: verification/mmu_tb.sv
/*
 * Sv32 MMU testbench top
 *   Clock, reset and DUT instance
 *   Galois LFSR for memory reply delays
 *   Page-table memory model with a read counter
 *   Value checks and the PTE address stability assertion
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

  localparam int          TLB_ENTRIES = 4;
  localparam int          CLK_PERIOD  = 100;      // ns
  localparam logic [31:0] LFSR_SEED   = 32'h9d11;
  localparam int          TIMEOUT     = 64;       // Cycles allowed per wait

  // ====================================================================
  // Page table layout
  // ====================================================================
  localparam logic [21:0] ROOT_PPN  = 22'h10;     // Root table at 0x10000
  localparam logic [21:0] L0_PPN    = 22'h11;     // Level-0 table for VPN[1] = 1
  localparam logic [31:0] SATP_SV32 = {1'b1, 9'd0, ROOT_PPN};
  localparam logic [7:0]  FL_PTR    = 8'h01;      // V only
  localparam logic [7:0]  FL_RW     = 8'hC7;      // D A W R V
  localparam logic [7:0]  FL_RO     = 8'h43;      // A R V
  localparam logic [7:0]  FL_URW    = 8'hD7;      // D A U W R V
  localparam logic [7:0]  FL_XO     = 8'h49;      // A X V
  localparam logic [7:0]  FL_RWX    = 8'hCF;

  logic        clk = 1'b0;
  logic        reset_n;
  logic        req_valid;
  logic [31:0] req_vaddr;
  logic        req_is_store;
  logic        req_is_fetch;
  logic        resp_valid;
  logic [33:0] resp_paddr;
  logic        resp_page_fault;
  logic [31:0] resp_fault_vaddr;
  logic        ptw_req_valid;
  logic [33:0] ptw_req_addr;
  logic        ptw_resp_valid = 1'b0;   // Driven by the memory model
  logic [31:0] ptw_resp_data  = 32'h0;
  logic [31:0] satp;
  logic [1:0]  priv_mode;
  logic        sum;
  logic        mxr;
  logic        flush_all;
  logic        flush_vaddr;
  logic [31:0] flush_addr;

  logic [31:0] pt_mem [logic [33:0]];   // PTE words by byte address
  logic [31:0] lfsr;
  int unsigned mem_reads;               // Completed PTE reads

  mmu_top #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) mmu_top_i (
    .clk (clk), .reset_n (reset_n),
    .req_valid (req_valid), .req_vaddr (req_vaddr),
    .req_is_store (req_is_store), .req_is_fetch (req_is_fetch),
    .resp_valid (resp_valid), .resp_paddr (resp_paddr),
    .resp_page_fault (resp_page_fault), .resp_fault_vaddr (resp_fault_vaddr),
    .ptw_req_valid (ptw_req_valid), .ptw_req_addr (ptw_req_addr),
    .ptw_resp_valid (ptw_resp_valid), .ptw_resp_data (ptw_resp_data),
    .satp (satp), .priv_mode (priv_mode), .sum (sum), .mxr (mxr),
    .flush_all (flush_all), .flush_vaddr (flush_vaddr), .flush_addr (flush_addr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int unsigned val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | lfsr[0];  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  function automatic logic [21:0] leaf_ppn(input int idx);
    return 22'h2A_5000 + 22'(idx);  // Upper PA bits set on purpose
  endfunction

  // VPN[1] = 1, VPN[0] = idx
  function automatic logic [31:0] page_va(input int idx, input logic [11:0] off);
    return {10'd1, 10'(idx), off};
  endfunction

  task automatic load_page_table();
    pt_mem[{ROOT_PPN, 10'd1, 2'b00}] = make_pte(L0_PPN, FL_PTR);
    pt_mem[{ROOT_PPN, 10'd3, 2'b00}] = make_pte(22'h400, FL_RWX);  // Superpage leaf
    pt_mem[{L0_PPN, 10'd0, 2'b00}]   = make_pte(leaf_ppn(0), FL_RW);
    pt_mem[{L0_PPN, 10'd1, 2'b00}]   = make_pte(leaf_ppn(1), FL_RW);
    pt_mem[{L0_PPN, 10'd2, 2'b00}]   = make_pte(leaf_ppn(2), FL_RO);
    pt_mem[{L0_PPN, 10'd3, 2'b00}]   = make_pte(leaf_ppn(3), FL_URW);
    pt_mem[{L0_PPN, 10'd4, 2'b00}]   = make_pte(leaf_ppn(4), FL_XO);
    pt_mem[{L0_PPN, 10'd6, 2'b00}]   = make_pte(22'h12, FL_PTR);   // Pointer at level 0
    // Pages 8 and up for eviction, entry 5 left invalid
    for (int i = 8; i <= 8 + TLB_ENTRIES; i++) begin
      pt_mem[{L0_PPN, 10'(i), 2'b00}] = make_pte(leaf_ppn(i), FL_RW);
    end
  endtask

  // ====================================================================
  // PTE memory model
  // ====================================================================
  always begin : mem_model
    int unsigned delay;
    @(negedge clk);
    if (reset_n && ptw_req_valid && !ptw_resp_valid) begin
      draw_bits(2, delay);            // 0 to 3 cycles
      repeat (delay) @(negedge clk);
      ptw_resp_data  = pt_mem.exists(ptw_req_addr) ? pt_mem[ptw_req_addr] : 32'h0;
      ptw_resp_valid = 1'b1;
      mem_reads++;
      @(negedge clk);
      ptw_resp_valid = 1'b0;          // One-cycle reply
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [33:0] exp, input logic [33:0] act);
    assert (act === exp)
    else begin
      $display("ERROR %s: expected 0x%h, actual 0x%h", name, exp, act);
      abort_run("A response value did not match");
    end
  endtask

  // Address held for as long as the read is pending
  assert property (@(posedge clk) disable iff (!reset_n)
                   (ptw_req_valid && $past(ptw_req_valid)) |-> $stable(ptw_req_addr))
  else abort_run("ptw_req_addr changed while ptw_req_valid was high");

`include "mmu_tb_tests.svh"

  initial begin : main
    reset_n      = 1'b0;
    req_valid    = 1'b0;
    req_vaddr    = 32'h0;
    req_is_store = 1'b0;
    req_is_fetch = 1'b0;
    satp         = 32'h0;
    priv_mode    = mmu_pkg::PRIV_S;
    sum          = 1'b0;
    mxr          = 1'b0;
    flush_all    = 1'b0;
    flush_vaddr  = 1'b0;
    flush_addr   = 32'h0;
    lfsr         = LFSR_SEED;
    mem_reads    = 0;
    load_page_table();
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    bare_mode_pass();
    walk_then_hit();
    permission_rules();
    walk_faults();
    flush_behavior();
    round_robin_evict();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/mmu_top.sv
/*
 * Sv32 MMU top level
 *   TLB and walk controller instances
 *   Core, CSR, flush and PTE memory ports
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                          clk,
  input  logic                          reset_n,
  // Core request and response
  input  logic                          req_valid,
  input  logic [mmu_pkg::XLEN-1:0]      req_vaddr,
  input  logic                          req_is_store,
  input  logic                          req_is_fetch,
  output logic                          resp_valid,       // One-cycle pulse
  output logic [mmu_pkg::PA_BITS-1:0]   resp_paddr,
  output logic                          resp_page_fault,
  output logic [mmu_pkg::XLEN-1:0]      resp_fault_vaddr,
  // PTE memory port
  output logic                          ptw_req_valid,
  output logic [mmu_pkg::PA_BITS-1:0]   ptw_req_addr,
  input  logic                          ptw_resp_valid,
  input  logic [mmu_pkg::XLEN-1:0]      ptw_resp_data,
  // CSR state
  input  logic [mmu_pkg::XLEN-1:0]      satp,
  input  logic [1:0]                    priv_mode,
  input  logic                          sum,
  input  logic                          mxr,
  // TLB maintenance
  input  logic                          flush_all,
  input  logic                          flush_vaddr,
  input  logic [mmu_pkg::XLEN-1:0]      flush_addr
);

  logic                                tlb_hit;
  logic [mmu_pkg::PPN_BITS-1:0]        tlb_ppn;
  logic [7:0]                          tlb_flags;
  logic                                fill_en;
  logic [mmu_pkg::VPN_FULL_BITS-1:0]   fill_vpn;
  logic [mmu_pkg::PPN_BITS-1:0]        fill_ppn;
  logic [7:0]                          fill_flags;

  mmu_tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) tlb_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .lookup_vaddr (req_vaddr),
    .tlb_hit      (tlb_hit),
    .tlb_ppn      (tlb_ppn),
    .tlb_flags    (tlb_flags),
    .fill_en      (fill_en),
    .fill_vpn     (fill_vpn),
    .fill_ppn     (fill_ppn),
    .fill_flags   (fill_flags),
    .flush_all    (flush_all),
    .flush_vaddr  (flush_vaddr),
    .flush_addr   (flush_addr)
  );

  mmu_walk_ctrl walk_ctrl_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .req_valid        (req_valid),
    .req_vaddr        (req_vaddr),
    .req_is_store     (req_is_store),
    .req_is_fetch     (req_is_fetch),
    .satp             (satp),
    .priv_mode        (priv_mode),
    .sum              (sum),
    .mxr              (mxr),
    .tlb_hit          (tlb_hit),
    .tlb_ppn          (tlb_ppn),
    .tlb_flags        (tlb_flags),
    .fill_en          (fill_en),
    .fill_vpn         (fill_vpn),
    .fill_ppn         (fill_ppn),
    .fill_flags       (fill_flags),
    .ptw_req_valid    (ptw_req_valid),
    .ptw_req_addr     (ptw_req_addr),
    .ptw_resp_valid   (ptw_resp_valid),
    .ptw_resp_data    (ptw_resp_data),
    .resp_valid       (resp_valid),
    .resp_paddr       (resp_paddr),
    .resp_page_fault  (resp_page_fault),
    .resp_fault_vaddr (resp_fault_vaddr)
  );

endmodule

`default_nettype wire

// File: hw/mmu_walk_ctrl.sv
/*
 * MMU request sequencer
 *   Bare mode and TLB hit answers
 *   Two-level Sv32 page table walk
 *   TLB fill and fault response
 *   Release wait closing each exchange
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_walk_ctrl (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                req_valid,
  input  logic [mmu_pkg::XLEN-1:0]            req_vaddr,
  input  logic                                req_is_store,
  input  logic                                req_is_fetch,
  input  logic [mmu_pkg::XLEN-1:0]            satp,
  input  logic [1:0]                          priv_mode,
  input  logic                                sum,
  input  logic                                mxr,
  input  logic                                tlb_hit,
  input  logic [mmu_pkg::PPN_BITS-1:0]        tlb_ppn,
  input  logic [7:0]                          tlb_flags,
  output logic                                fill_en,
  output logic [mmu_pkg::VPN_FULL_BITS-1:0]   fill_vpn,
  output logic [mmu_pkg::PPN_BITS-1:0]        fill_ppn,
  output logic [7:0]                          fill_flags,
  output logic                                ptw_req_valid,
  output logic [mmu_pkg::PA_BITS-1:0]         ptw_req_addr,
  input  logic                                ptw_resp_valid,
  input  logic [mmu_pkg::XLEN-1:0]            ptw_resp_data,
  output logic                                resp_valid,
  output logic [mmu_pkg::PA_BITS-1:0]         resp_paddr,
  output logic                                resp_page_fault,
  output logic [mmu_pkg::XLEN-1:0]            resp_fault_vaddr
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_READ    = 3'd1;  // PTE read in flight
  localparam logic [2:0] ST_FILL    = 3'd2;  // fill_en cycle
  localparam logic [2:0] ST_RESPOND = 3'd3;  // Translation pulse
  localparam logic [2:0] ST_FAULT   = 3'd4;  // Fault pulse
  localparam logic [2:0] ST_RELEASE = 3'd5;  // Wait for req_valid low

  logic [2:0]                 state_q;
  logic                       level_q;    // 1 = root table
  logic [mmu_pkg::XLEN-1:0]   vaddr_q;    // Latched on a miss
  logic                       store_q;
  logic                       fetch_q;
  mmu_pkg::pte_u              rd_pte;     // Reply word view
  mmu_pkg::pte_u              pte_q;      // Leaf kept for the fill

  logic xlat_en, accept, got_pte, pte_leaf, pte_ptr, walk_ok, walk_next, allowed;
  logic [7:0] chk_flags;

  assign rd_pte.raw = ptw_resp_data;

  // Sv32 on and below M mode
  assign xlat_en = satp[mmu_pkg::SATP_MODE_BIT] && (priv_mode != mmu_pkg::PRIV_M);
  assign accept  = (state_q == ST_IDLE) && req_valid;
  assign got_pte = (state_q == ST_READ) && ptw_req_valid && ptw_resp_valid;

  assign pte_leaf = rd_pte.fields.flags[mmu_pkg::PTE_R] || rd_pte.fields.flags[mmu_pkg::PTE_X];
  assign pte_ptr  = rd_pte.fields.flags[mmu_pkg::PTE_V] && !pte_leaf &&
                    !rd_pte.fields.flags[mmu_pkg::PTE_W];
  assign walk_ok   = got_pte && pte_leaf && !level_q && allowed;  // Superpages fault
  assign walk_next = got_pte && pte_ptr && level_q;

  // TLB flags when idle, reply flags during the walk
  assign chk_flags = (state_q == ST_IDLE) ? tlb_flags : rd_pte.fields.flags;

  mmu_perm_check perm_check_i (
    .flags     (chk_flags),
    .is_store  ((state_q == ST_IDLE) ? req_is_store : store_q),
    .is_fetch  ((state_q == ST_IDLE) ? req_is_fetch : fetch_q),
    .priv_mode (priv_mode),
    .sum       (sum),
    .mxr       (mxr),
    .allowed   (allowed)
  );

  // ====================================================================
  // Control FSM
  // ====================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q         <= ST_IDLE;
      level_q         <= 1'b0;
      ptw_req_valid   <= 1'b0;
      resp_valid      <= 1'b0;
      resp_page_fault <= 1'b0;
    end else begin
      resp_valid      <= 1'b0;  // Pulses by default
      resp_page_fault <= 1'b0;
      case (state_q)
        ST_IDLE: if (accept) begin
          if (!xlat_en || (tlb_hit && allowed)) begin
            resp_valid <= 1'b1;
            state_q    <= ST_RESPOND;
          end else if (tlb_hit) begin
            resp_valid      <= 1'b1;
            resp_page_fault <= 1'b1;
            state_q         <= ST_FAULT;
          end else begin
            ptw_req_valid <= 1'b1;  // Root PTE read
            level_q       <= 1'b1;
            state_q       <= ST_READ;
          end
        end
        ST_READ: begin
          if (!ptw_req_valid) begin
            ptw_req_valid <= 1'b1;  // Level-0 read after a gap cycle
          end else if (ptw_resp_valid) begin
            ptw_req_valid <= 1'b0;
            if (walk_ok) begin
              state_q <= ST_FILL;
            end else if (walk_next) begin
              level_q <= 1'b0;
            end else begin
              resp_valid      <= 1'b1;
              resp_page_fault <= 1'b1;
              state_q         <= ST_FAULT;
            end
          end
        end
        ST_FILL: begin
          resp_valid <= 1'b1;
          state_q    <= ST_RESPOND;
        end
        ST_RESPOND, ST_FAULT: state_q <= ST_RELEASE;
        ST_RELEASE: if (!req_valid) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ====================================================================
  // Addresses and latched request
  // ====================================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      vaddr_q      <= req_vaddr;
      store_q      <= req_is_store;
      fetch_q      <= req_is_fetch;
      ptw_req_addr <= {satp[mmu_pkg::PPN_BITS-1:0],
                       req_vaddr[mmu_pkg::XLEN-1 -: mmu_pkg::VPN_BITS],
                       {mmu_pkg::PTE_SHIFT{1'b0}}};  // satp.ppn*4K + VPN[1]*4
      if (!xlat_en) begin
        resp_paddr <= {{(mmu_pkg::PA_BITS - mmu_pkg::XLEN){1'b0}}, req_vaddr};
      end else if (tlb_hit && allowed) begin
        resp_paddr <= {tlb_ppn, req_vaddr[mmu_pkg::PAGE_SHIFT-1:0]};
      end else if (tlb_hit) begin
        resp_fault_vaddr <= req_vaddr;
      end
    end
    if (got_pte) begin
      pte_q <= rd_pte;
      if (walk_next) begin
        ptw_req_addr <= {rd_pte.fields.ppn,
                         vaddr_q[mmu_pkg::PAGE_SHIFT +: mmu_pkg::VPN_BITS],
                         {mmu_pkg::PTE_SHIFT{1'b0}}};
      end else if (!walk_ok) begin
        resp_fault_vaddr <= vaddr_q;
      end
    end
    if (state_q == ST_FILL) begin
      resp_paddr <= {pte_q.fields.ppn, vaddr_q[mmu_pkg::PAGE_SHIFT-1:0]};
    end
  end

  // Fill straight from the kept leaf
  assign fill_en    = (state_q == ST_FILL);
  assign fill_vpn   = vaddr_q[mmu_pkg::XLEN-1:mmu_pkg::PAGE_SHIFT];
  assign fill_ppn   = pte_q.fields.ppn;
  assign fill_flags = pte_q.fields.flags;

endmodule

`default_nettype wire

// File: hw/mmu_tlb.sv
/*
 * Fully associative TLB of 4 KB translations
 *   Valid, VPN, PPN and flag arrays
 *   Combinational lookup on the full VPN
 *   Fill at the round-robin victim pointer
 *   Flush-all and flush-by-address
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_tlb #(
  parameter int TLB_ENTRIES = 4  // Power of two, at least 2
) (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic [mmu_pkg::XLEN-1:0]            lookup_vaddr,
  output logic                                tlb_hit,
  output logic [mmu_pkg::PPN_BITS-1:0]        tlb_ppn,
  output logic [7:0]                          tlb_flags,
  input  logic                                fill_en,      // One-cycle write strobe
  input  logic [mmu_pkg::VPN_FULL_BITS-1:0]   fill_vpn,
  input  logic [mmu_pkg::PPN_BITS-1:0]        fill_ppn,
  input  logic [7:0]                          fill_flags,
  input  logic                                flush_all,
  input  logic                                flush_vaddr,
  input  logic [mmu_pkg::XLEN-1:0]            flush_addr
);

  localparam int IDX_BITS = $clog2(TLB_ENTRIES);

  // ====================================================================
  // Storage
  // ====================================================================
  logic [TLB_ENTRIES-1:0]              valid_q;
  logic [mmu_pkg::VPN_FULL_BITS-1:0]   vpn_q   [TLB_ENTRIES];
  logic [mmu_pkg::PPN_BITS-1:0]        ppn_q   [TLB_ENTRIES];
  logic [7:0]                          flags_q [TLB_ENTRIES];
  logic [IDX_BITS-1:0]                 victim_q;  // Next entry to replace

  logic [mmu_pkg::VPN_FULL_BITS-1:0]   lookup_vpn;
  logic [mmu_pkg::VPN_FULL_BITS-1:0]   flush_vpn;

  assign lookup_vpn = lookup_vaddr[mmu_pkg::XLEN-1:mmu_pkg::PAGE_SHIFT];
  assign flush_vpn  = flush_addr[mmu_pkg::XLEN-1:mmu_pkg::PAGE_SHIFT];

  // Lookup across all entries
  always_comb begin
    tlb_hit   = 1'b0;
    tlb_ppn   = '0;
    tlb_flags = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_q[i] && (vpn_q[i] == lookup_vpn)) begin
        tlb_hit   = 1'b1;
        tlb_ppn   = ppn_q[i];
        tlb_flags = flags_q[i];
      end
    end
  end

  // ====================================================================
  // Valid bits and victim pointer
  // ====================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else begin
      if (fill_en) begin
        valid_q[victim_q] <= 1'b1;
        victim_q          <= victim_q + IDX_BITS'(1);  // Wraps at TLB_ENTRIES
      end
      // Flushes override a same-cycle fill
      if (flush_all) begin
        valid_q <= '0;
      end else if (flush_vaddr) begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
          if (vpn_q[i] == flush_vpn) valid_q[i] <= 1'b0;
        end
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (fill_en) begin
      vpn_q[victim_q]   <= fill_vpn;
      ppn_q[victim_q]   <= fill_ppn;
      flags_q[victim_q] <= fill_flags;
    end
  end

endmodule

`default_nettype wire

// File: hw/mmu_perm_check.sv
/*
 * Leaf PTE permission check for one access
 *   Malformed PTE rejection
 *   U/S page rules with SUM
 *   Load, store and fetch rights with MXR
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_perm_check (
  input  logic [7:0] flags,      // PTE flags byte
  input  logic       is_store,
  input  logic       is_fetch,
  input  logic [1:0] priv_mode,
  input  logic       sum,        // S-mode may touch U pages
  input  logic       mxr,        // X pages readable
  output logic       allowed
);

  logic v, r, w, x, u;
  logic leaf_ok;   // Valid and well-formed leaf
  logic priv_ok;   // Privilege vs U bit
  logic type_ok;   // Access type vs R/W/X

  assign v = flags[mmu_pkg::PTE_V];
  assign r = flags[mmu_pkg::PTE_R];
  assign w = flags[mmu_pkg::PTE_W];
  assign x = flags[mmu_pkg::PTE_X];
  assign u = flags[mmu_pkg::PTE_U];

  // Pointer (no R/W/X) and W-without-R are both rejected
  assign leaf_ok = v && (r || w || x) && !(w && !r);

  always_comb begin
    case (priv_mode)
      mmu_pkg::PRIV_U: priv_ok = u;          // User needs U page
      mmu_pkg::PRIV_S: priv_ok = !u || sum;  // U page only with SUM
      default:         priv_ok = 1'b1;       // M mode is never translated
    endcase
  end

  // Fetch needs X, store needs W, load needs R or X under MXR
  assign type_ok = is_fetch ? x :
                   is_store ? w :
                   (r || (x && mxr));

  assign allowed = leaf_ok && priv_ok && type_ok;

endmodule

`default_nettype wire

// File: hw/mmu_pkg.sv
/*
 * Sv32 MMU shared definitions
 *   Address, VPN and PPN widths
 *   PTE flag bit positions
 *   Privilege mode codes and the satp mode bit
 *   pte_u union with raw and field views of one PTE
 */
`default_nettype none

package mmu_pkg;

  // ====================================================================
  // Address geometry
  // ====================================================================
  localparam int XLEN          = 32;  // VA and PTE width
  localparam int PA_BITS       = 34;  // Sv32 physical address
  localparam int PAGE_SHIFT    = 12;  // 4 KB pages
  localparam int VPN_BITS      = 10;  // One VPN slice
  localparam int VPN_FULL_BITS = 20;  // VPN[1] and VPN[0]
  localparam int PPN_BITS      = 22;
  localparam int PTE_SHIFT     = 2;   // 4-byte PTEs

  // satp layout
  localparam int SATP_MODE_BIT = 31;  // 1 selects Sv32

  // ====================================================================
  // PTE flag positions
  // ====================================================================
  localparam int PTE_V = 0;  // Valid
  localparam int PTE_R = 1;  // Readable
  localparam int PTE_W = 2;  // Writable
  localparam int PTE_X = 3;  // Executable
  localparam int PTE_U = 4;  // User page
  localparam int PTE_G = 5;  // Global
  localparam int PTE_A = 6;  // Accessed
  localparam int PTE_D = 7;  // Dirty

  // Privilege modes
  localparam logic [1:0] PRIV_U = 2'd0;
  localparam logic [1:0] PRIV_S = 2'd1;
  localparam logic [1:0] PRIV_M = 2'd3;  // 2 is reserved

  // ====================================================================
  // PTE word
  // ====================================================================
  // Same 32 bits seen two ways by the walker
  typedef union packed {
    logic [XLEN-1:0] raw;            // Word as returned by memory
    struct packed {
      logic [PPN_BITS-1:0] ppn;      // PPN[1] and PPN[0]
      logic [1:0]          rsw;      // Software bits, ignored
      logic [7:0]          flags;    // D A G U X W R V
    } fields;
  } pte_u;

endpackage

`default_nettype wire
